// File: vlog.f
src/miss_pkg.sv
src/mem_pkg.sv
src/miss_alloc.sv
src/load_wait_queue.sv
src/line_fetch.sv
src/refill_ctrl.sv
src/dcache_miss.sv
bench/dcache_miss_properties.sv
bench/tb_dcache_miss.sv

// File: bench/miss_trace.txt
# columns: load address, lq_idx, expected word (all hex)
# one missed load per line
00001000 00 00000100
00001004 01 11111011
00002008 02 22222022
0000300c 03 33333033
0000100c 04 33333233
00004000 05 00000400
00005004 06 11111411
00002000 07 00000200
80000a48 08 2a222286
00005008 09 22222722
00006004 0a 11111711
80000a4c 0b 3b333397
00004004 0c 11111511

// File: bench/tb_dcache_miss.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_miss;

    localparam logic [31:0] SEED       = 32'h5949_227c;
    localparam int          WAIT_LIMIT = 2000;

    logic                  clk;
    logic                  rst;
    logic                  ren;
    miss_pkg::paddr_t      raddr;
    miss_pkg::lq_idx_t     lq_idx;
    logic                  rfull;
    logic                  ar_valid;
    miss_pkg::paddr_t      ar_addr;
    mem_pkg::mem_id_t      ar_id;
    logic                  ar_ready;
    logic                  r_valid;
    mem_pkg::mem_id_t      r_id;
    miss_pkg::word_t       r_data;
    logic                  r_last;
    logic                  refill_en;
    miss_pkg::paddr_t      refill_addr;
    miss_pkg::line_t       refill_data;
    logic                  refill_done;
    logic                  lq_en;
    miss_pkg::word_t       lq_data;
    miss_pkg::lq_idx_t     lq_idx_o;

    // memory and cache model state
    logic                  ar_hold;
    logic [31:0]           ar_rng;
    logic [31:0]           refill_rng;
    miss_pkg::line_addr_t  burst_line [mem_pkg::MEM_IDS];
    int                    burst_beat [mem_pkg::MEM_IDS];
    logic                  burst_busy [mem_pkg::MEM_IDS];
    mem_pkg::mem_id_t      last_id;
    miss_pkg::line_addr_t  ar_line;
    miss_pkg::line_addr_t  fill_line;
    int                    ar_total;
    int                    refill_total;
    int                    ar_per_line [miss_pkg::line_addr_t];
    int                    requested [miss_pkg::line_addr_t];
    miss_pkg::word_t       pending_word [int];

    dcache_miss dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // word k of line L is L xor k * 1111_1111
    function automatic miss_pkg::word_t line_word(input miss_pkg::line_addr_t line,
                                                  input int k);
        return {4'h0, line} ^ (32'(k) * 32'h1111_1111);
    endfunction

    function automatic miss_pkg::line_t build_line(input miss_pkg::line_addr_t line);
        miss_pkg::line_t l;
        for (int k = 0; k < mem_pkg::BEATS_PER_LINE; k++)
            l[k*32 +: 32] = line_word(line, k);
        return l;
    endfunction

    task automatic end_in_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR: %s", msg);
        end_in_failure();
    endtask

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s expected %0h actual %0h", name, expected, actual);
            end_in_failure();
        end
    endtask

    // one load held for one cycle and accepted unless rfull rises
    task automatic try_load(input logic [31:0] addr, input logic [4:0] idx,
                            input logic [31:0] word, output logic ok);
        ren    = 1'b1;
        raddr  = addr;
        lq_idx = idx;
        @(posedge clk);
        #1;
        ren = 1'b0;
        ok  = !rfull;
        if (ok) begin
            if (pending_word.exists(int'(idx)))
                report_problem($sformatf("lq index %0d reused while still waiting", idx));
            else
                pending_word[int'(idx)] = word;
        end
    endtask

    task automatic issue_load(input logic [31:0] addr, input logic [4:0] idx,
                              input logic [31:0] word);
        logic ok;
        int   tries;
        tries = 0;
        try_load(addr, idx, word, ok);
        while (!ok) begin
            tries++;
            if (tries > WAIT_LIMIT)
                report_problem($sformatf("load for lq index %0d refused on every retry", idx));
            else
                try_load(addr, idx, word, ok);
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (pending_word.num() != 0 || refill_en || ar_valid || refill_total != ar_total)
        begin
            if (cycles >= WAIT_LIMIT)
                report_problem("loads were not woken or lines not refilled before the timeout");
            else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
        // entries free a cycle after miss_end
        repeat (2) @(posedge clk);
        #1;
    endtask

    always begin : ar_responder
        @(posedge clk);
        if (rst && ar_valid && !ar_hold) begin
            ar_rng = xorshift(ar_rng);
            repeat (ar_rng % 4) @(posedge clk);
            #1 ar_ready = 1'b1;
            @(posedge clk);
            #1 ar_ready = 1'b0;
        end
    end

    always begin : memory_model
        @(posedge clk);
        if (rst && ar_valid && ar_ready) begin
            ar_line = ar_addr[31:miss_pkg::LINE_OFFSET_BITS];
            if (burst_busy[ar_id])
                report_problem("memory id reused while its burst is still running");
            else begin
                burst_line[ar_id] = ar_line;
                burst_beat[ar_id] = 0;
                burst_busy[ar_id] = 1'b1;
                ar_total++;
                if (ar_per_line.exists(ar_line))
                    ar_per_line[ar_line]++;
                else
                    ar_per_line[ar_line] = 1;
                if (requested.exists(ar_line))
                    requested[ar_line]++;
                else
                    requested[ar_line] = 1;
            end
        end
        #1;
        // alternate ids so bursts interleave
        if (burst_busy[~last_id])
            last_id = ~last_id;
        r_valid = burst_busy[last_id];
        r_id    = last_id;
        r_data  = line_word(burst_line[last_id], burst_beat[last_id]);
        r_last  = burst_busy[last_id] && (burst_beat[last_id] == mem_pkg::BEATS_PER_LINE - 1);
        if (burst_busy[last_id]) begin
            burst_beat[last_id]++;
            if (r_last)
                burst_busy[last_id] = 1'b0;
        end
    end

    always begin : cache_model
        @(posedge clk);
        if (rst && refill_en) begin
            refill_rng = xorshift(refill_rng);
            repeat (refill_rng % 4) @(posedge clk);
            #1 refill_done = 1'b1;
            @(posedge clk);
            #1 refill_done = 1'b0;
        end
    end

    always @(posedge clk) begin : refill_monitor
        if (rst && refill_en && refill_done) begin
            fill_line = refill_addr[31:miss_pkg::LINE_OFFSET_BITS];
            if (!requested.exists(fill_line))
                report_problem($sformatf("refill of line %0h that memory never supplied",
                                         fill_line));
            else begin
                check("refill address offset", '0, refill_addr[3:0]);
                check($sformatf("refill data of line %0h", fill_line), build_line(fill_line),
                      refill_data);
                refill_total++;
                requested[fill_line]--;
                if (requested[fill_line] == 0)
                    requested.delete(fill_line);
            end
        end
    end

    always @(posedge clk) begin : wakeup_monitor
        if (rst && lq_en) begin
            if (!pending_word.exists(int'(lq_idx_o)))
                report_problem($sformatf("wakeup for lq index %0d with no waiting load",
                                         lq_idx_o));
            else begin
                check($sformatf("wakeup data for lq %0d", lq_idx_o),
                      pending_word[int'(lq_idx_o)], lq_data);
                pending_word.delete(int'(lq_idx_o));
            end
        end
    end

    always @(posedge clk) begin
        if (dut.props.fail_count != 0)
            report_problem("a handshake assertion on the DUT failed");
    end

    initial begin : stimulus
        int          fd;
        int          loads;
        string       text;
        logic [31:0] addr;
        logic [31:0] idx;
        logic [31:0] word;
        logic        ok;
        clk          = 1'b0;
        rst          = 1'b0;
        ren          = 1'b0;
        raddr        = '0;
        lq_idx       = '0;
        ar_ready     = 1'b0;
        r_valid      = 1'b0;
        r_id         = '0;
        r_data       = '0;
        r_last       = 1'b0;
        refill_done  = 1'b0;
        ar_hold      = 1'b0;
        ar_rng       = SEED;
        refill_rng   = xorshift(SEED);
        last_id      = '0;
        ar_total     = 0;
        refill_total = 0;
        loads        = 0;
        burst_busy   = '{default: 1'b0};
        burst_beat   = '{default: 0};
        burst_line   = '{default: '0};
        repeat (4) @(posedge clk);
        #1 rst = 1'b1;
        @(posedge clk);
        #1;

        // trace loads under random memory and cache delays
        fd = $fopen("bench/miss_trace.txt", "r");
        if (fd == 0)
            report_problem("cannot open bench/miss_trace.txt");
        while ($fgets(text, fd) != 0) begin
            if (text.len() > 0 && text[0] != "#" &&
                $sscanf(text, "%h %h %h", addr, idx, word) == 3) begin
                check($sformatf("trace word for lq %0d", idx),
                      line_word(addr[31:4], int'(addr[3:2])), word);
                issue_load(addr, idx[4:0], word);
                loads++;
            end
        end
        $fclose(fd);
        if (loads == 0)
            report_problem("trace file holds no loads");
        drain();

        // loads merging into one outstanding fetch
        ar_per_line.delete();
        ar_hold = 1'b1;
        issue_load(32'h0002_0000, 5'd16, line_word(28'h0002000, 0));
        issue_load(32'h0002_0004, 5'd17, line_word(28'h0002000, 1));
        issue_load(32'h0002_000c, 5'd18, line_word(28'h0002000, 3));
        ar_hold = 1'b0;
        drain();
        check("ar handshakes for merged line", 1, ar_per_line[28'h0002000]);

        // fifth new line finds no free entry
        ar_hold = 1'b1;
        for (int i = 0; i < 5; i++) begin
            addr = 32'h0003_0000 + 32'(i * 16);
            try_load(addr, 5'(20 + i), line_word(addr[31:4], 0), ok);
            if (i < 4)
                check($sformatf("new line load %0d accepted", i), 1, ok);
            else
                check("rfull after fifth load", 1, rfull);
        end
        ar_hold = 1'b0;
        drain();
        try_load(32'h0003_0040, 5'd24, line_word(28'h0003004, 0), ok);
        check("retry of fifth load accepted", 1, ok);
        drain();

        if (dut.props.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_problem("a handshake assertion on the DUT failed");
        end
    end

endmodule

`default_nettype wire

// File: bench/dcache_miss_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_properties (
    input wire                    clk,
    input wire                    rst,
    input wire                    ren,
    input wire                    rfull,
    input wire                    ar_valid,
    input wire                    ar_ready,
    input wire miss_pkg::paddr_t  ar_addr,
    input wire mem_pkg::mem_id_t  ar_id,
    input wire                    refill_en,
    input wire                    refill_done,
    input wire miss_pkg::paddr_t  refill_addr,
    input wire miss_pkg::line_t   refill_data
);

    int unsigned fail_count = 0;

    // read request holds until taken
    ar_stable_a: assert property (@(posedge clk) disable iff (!rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_id))
    else begin
        fail_count++;
        $error("ar_valid dropped or ar_addr/ar_id changed before ar_ready");
    end

    refill_stable_a: assert property (@(posedge clk) disable iff (!rst)
        refill_en && !refill_done |=> refill_en && $stable(refill_addr) &&
            $stable(refill_data))
    else begin
        fail_count++;
        $error("refill_en dropped or refill data changed before refill_done");
    end

    // a refusal always answers a load
    rfull_cause_a: assert property (@(posedge clk) disable iff (!rst)
        $rose(rfull) |-> $past(ren))
    else begin
        fail_count++;
        $error("rfull rose without a load in the cycle before");
    end

endmodule

bind dcache_miss dcache_miss_properties props (.*);

`default_nettype wire

// File: src/dcache_miss.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_miss (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        ren,
    input  wire miss_pkg::paddr_t      raddr,
    input  wire miss_pkg::lq_idx_t     lq_idx,
    output logic                       rfull,
    output logic                       ar_valid,
    output miss_pkg::paddr_t           ar_addr,
    output mem_pkg::mem_id_t           ar_id,
    input  wire                        ar_ready,
    input  wire                        r_valid,
    input  wire mem_pkg::mem_id_t      r_id,
    input  wire miss_pkg::word_t       r_data,
    input  wire                        r_last,
    output logic                       refill_en,
    output miss_pkg::paddr_t           refill_addr,
    output miss_pkg::line_t            refill_data,
    input  wire                        refill_done,
    output logic                       lq_en,
    output miss_pkg::word_t            lq_data,
    output miss_pkg::lq_idx_t          lq_idx_o
);

    logic                                  slot_free;
    logic                                  alloc_ok;
    miss_pkg::miss_idx_t                   alloc_idx;
    logic [miss_pkg::MISS_ENTRIES-1:0]     entry_valid;
    miss_pkg::line_addr_t                  entry_line [miss_pkg::MISS_ENTRIES];
    logic [miss_pkg::MISS_ENTRIES-1:0]     fetch_pending;
    logic [miss_pkg::MISS_ENTRIES-1:0]     rhit_vec;
    logic                                  fetch_issued;
    miss_pkg::miss_idx_t                   fetch_issued_idx;
    logic [miss_pkg::MISS_ENTRIES-1:0]     line_ready;
    miss_pkg::line_t                       line_data [miss_pkg::MISS_ENTRIES];
    logic [miss_pkg::MISS_ENTRIES-1:0]     waiting_vec;
    logic                                  miss_end;
    miss_pkg::miss_idx_t                   miss_end_idx;

    miss_alloc u_alloc (
        .clk, .rst, .ren, .raddr, .slot_free, .fetch_issued, .fetch_issued_idx,
        .miss_end, .miss_end_idx, .rfull, .alloc_ok, .alloc_idx, .entry_valid,
        .entry_line, .fetch_pending, .rhit_vec
    );

    load_wait_queue u_wait (
        .clk, .rst, .alloc_ok, .alloc_idx, .raddr, .lq_idx, .line_ready, .line_data,
        .slot_free, .waiting_vec, .lq_en, .lq_data, .lq_idx_o
    );

    line_fetch u_fetch (
        .clk, .rst, .entry_valid, .entry_line, .fetch_pending, .ar_ready, .r_valid,
        .r_id, .r_data, .r_last, .miss_end, .miss_end_idx, .ar_valid, .ar_addr,
        .ar_id, .fetch_issued, .fetch_issued_idx, .line_ready, .line_data
    );

    refill_ctrl u_refill (
        .clk, .rst, .entry_valid, .entry_line, .line_ready, .line_data, .waiting_vec,
        .rhit_vec, .refill_done, .refill_en, .refill_addr, .refill_data, .miss_end,
        .miss_end_idx
    );

endmodule

`default_nettype wire

// File: src/refill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module refill_ctrl (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire [miss_pkg::MISS_ENTRIES-1:0]      entry_valid,
    input  wire miss_pkg::line_addr_t             entry_line [miss_pkg::MISS_ENTRIES],
    input  wire [miss_pkg::MISS_ENTRIES-1:0]      line_ready,
    input  wire miss_pkg::line_t                  line_data [miss_pkg::MISS_ENTRIES],
    input  wire [miss_pkg::MISS_ENTRIES-1:0]      waiting_vec,
    input  wire [miss_pkg::MISS_ENTRIES-1:0]      rhit_vec,
    input  wire                                   refill_done,
    output logic                                  refill_en,
    output miss_pkg::paddr_t                      refill_addr,
    output miss_pkg::line_t                       refill_data,
    output logic                                  miss_end,
    output miss_pkg::miss_idx_t                   miss_end_idx
);

    logic [miss_pkg::MISS_ENTRIES-1:0]     refilled;
    logic [miss_pkg::MISS_ENTRIES-1:0]     cand;
    logic [miss_pkg::MISS_ENTRIES-1:0]     end_vec;
    miss_pkg::miss_idx_t                   cand_idx;
    miss_pkg::miss_idx_t                   refill_idx;

    always_comb begin
        cand_idx     = '0;
        miss_end_idx = '0;
        for (int i = miss_pkg::MISS_ENTRIES - 1; i >= 0; i--) begin
            cand[i]    = entry_valid[i] && line_ready[i] && !refilled[i];
            end_vec[i] = entry_valid[i] && refilled[i] && !waiting_vec[i] && !rhit_vec[i];
            if (cand[i])
                cand_idx = miss_pkg::miss_idx_t'(i);
            if (end_vec[i])
                miss_end_idx = miss_pkg::miss_idx_t'(i);
        end
    end

    assign miss_end    = |end_vec;
    assign refill_addr = {entry_line[refill_idx], {miss_pkg::LINE_OFFSET_BITS{1'b0}}};
    assign refill_data = line_data[refill_idx];

    // offer held until the cache takes it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            refill_en <= 1'b0;
            refilled  <= '0;
        end else begin
            if (!refill_en && (|cand)) begin
                refill_en <= 1'b1;
            end else if (refill_en && refill_done) begin
                refill_en            <= 1'b0;
                refilled[refill_idx] <= 1'b1;
            end
            if (miss_end)
                refilled[miss_end_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!refill_en && (|cand))
            refill_idx <= cand_idx;
    end

endmodule

`default_nettype wire

// File: src/line_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module line_fetch (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire [miss_pkg::MISS_ENTRIES-1:0]      entry_valid,
    input  wire miss_pkg::line_addr_t             entry_line [miss_pkg::MISS_ENTRIES],
    input  wire [miss_pkg::MISS_ENTRIES-1:0]      fetch_pending,
    input  wire                                   ar_ready,
    input  wire                                   r_valid,
    input  wire mem_pkg::mem_id_t                 r_id,
    input  wire miss_pkg::word_t                  r_data,
    input  wire                                   r_last,
    input  wire                                   miss_end,
    input  wire miss_pkg::miss_idx_t              miss_end_idx,
    output logic                                  ar_valid,
    output miss_pkg::paddr_t                      ar_addr,
    output mem_pkg::mem_id_t                      ar_id,
    output logic                                  fetch_issued,
    output miss_pkg::miss_idx_t                   fetch_issued_idx,
    output logic [miss_pkg::MISS_ENTRIES-1:0]     line_ready,
    output miss_pkg::line_t                       line_data [miss_pkg::MISS_ENTRIES]
);

    mem_pkg::fetch_state_t                 state;
    logic [miss_pkg::MISS_ENTRIES-1:0]     cand;
    miss_pkg::miss_idx_t                   cand_idx;
    logic [mem_pkg::MEM_IDS-1:0]           id_busy;
    mem_pkg::mem_id_t                      free_id;
    miss_pkg::miss_idx_t                   id_map [mem_pkg::MEM_IDS];
    mem_pkg::beat_idx_t                    beat_cnt [mem_pkg::MEM_IDS];
    logic                                  start;

    always_comb begin
        cand_idx = '0;
        free_id  = '0;
        for (int i = miss_pkg::MISS_ENTRIES - 1; i >= 0; i--) begin
            // pending bit of an entry just issued is still set for one cycle
            cand[i] = entry_valid[i] && fetch_pending[i] &&
                      !(fetch_issued && (fetch_issued_idx == miss_pkg::miss_idx_t'(i)));
            if (cand[i])
                cand_idx = miss_pkg::miss_idx_t'(i);
        end
        for (int i = mem_pkg::MEM_IDS - 1; i >= 0; i--) begin
            if (!id_busy[i])
                free_id = mem_pkg::mem_id_t'(i);
        end
    end

    assign start = (state == mem_pkg::IDLE) && (|cand) && !(&id_busy);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state        <= mem_pkg::IDLE;
            ar_valid     <= 1'b0;
            fetch_issued <= 1'b0;
            id_busy      <= '0;
            line_ready   <= '0;
            beat_cnt     <= '{default: '0};
        end else begin
            fetch_issued <= 1'b0;
            case (state)
                mem_pkg::IDLE: begin
                    if (start) begin
                        ar_valid         <= 1'b1;
                        id_busy[free_id] <= 1'b1;
                        state            <= mem_pkg::REQ;
                    end
                end
                mem_pkg::REQ: begin
                    if (ar_ready) begin
                        ar_valid     <= 1'b0;
                        fetch_issued <= 1'b1;
                        state        <= mem_pkg::IDLE;
                    end
                end
            endcase
            if (r_valid) begin
                beat_cnt[r_id] <= r_last ? '0 : beat_cnt[r_id] + 1'b1;
                if (r_last) begin
                    id_busy[r_id]            <= 1'b0;
                    line_ready[id_map[r_id]] <= 1'b1;
                end
            end
            if (miss_end)
                line_ready[miss_end_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ar_addr          <= {entry_line[cand_idx], {miss_pkg::LINE_OFFSET_BITS{1'b0}}};
            ar_id            <= free_id;
            id_map[free_id]  <= cand_idx;
            fetch_issued_idx <= cand_idx;
        end
        // beats land in the entry owning this id
        if (r_valid)
            line_data[id_map[r_id]][beat_cnt[r_id]*($bits(miss_pkg::line_t) /
                mem_pkg::BEATS_PER_LINE) +: $bits(miss_pkg::word_t)] <= r_data;
    end

endmodule

`default_nettype wire

// File: src/load_wait_queue.sv
`timescale 1ns/1ps
`default_nettype none

module load_wait_queue (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   alloc_ok,
    input  wire miss_pkg::miss_idx_t              alloc_idx,
    input  wire miss_pkg::paddr_t                 raddr,
    input  wire miss_pkg::lq_idx_t                lq_idx,
    input  wire [miss_pkg::MISS_ENTRIES-1:0]      line_ready,
    input  wire miss_pkg::line_t                  line_data [miss_pkg::MISS_ENTRIES],
    output logic                                  slot_free,
    output logic [miss_pkg::MISS_ENTRIES-1:0]     waiting_vec,
    output logic                                  lq_en,
    output miss_pkg::word_t                       lq_data,
    output miss_pkg::lq_idx_t                     lq_idx_o
);

    logic [miss_pkg::WAIT_SLOTS-1:0]          slot_valid;
    logic [miss_pkg::WAIT_SLOTS-1:0]          rel_vec;
    miss_pkg::miss_idx_t                      slot_miss [miss_pkg::WAIT_SLOTS];
    miss_pkg::word_sel_t                      slot_sel [miss_pkg::WAIT_SLOTS];
    miss_pkg::lq_idx_t                        slot_lq [miss_pkg::WAIT_SLOTS];
    logic [$clog2(miss_pkg::WAIT_SLOTS)-1:0]  free_slot;
    logic [$clog2(miss_pkg::WAIT_SLOTS)-1:0]  rel_slot;

    always_comb begin
        free_slot   = '0;
        rel_slot    = '0;
        waiting_vec = '0;
        for (int i = miss_pkg::WAIT_SLOTS - 1; i >= 0; i--) begin
            rel_vec[i] = slot_valid[i] && line_ready[slot_miss[i]];
            if (!slot_valid[i])
                free_slot = i[$clog2(miss_pkg::WAIT_SLOTS)-1:0];
            if (rel_vec[i])
                rel_slot = i[$clog2(miss_pkg::WAIT_SLOTS)-1:0];
            // slot being released still counts as waiting this cycle
            if (slot_valid[i])
                waiting_vec[slot_miss[i]] = 1'b1;
        end
    end

    assign slot_free = ~&slot_valid;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slot_valid <= '0;
            lq_en      <= 1'b0;
        end else begin
            lq_en <= |rel_vec;
            if (|rel_vec)
                slot_valid[rel_slot] <= 1'b0;
            if (alloc_ok)
                slot_valid[free_slot] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_ok) begin
            slot_miss[free_slot] <= alloc_idx;
            slot_sel[free_slot]  <= raddr[miss_pkg::LINE_OFFSET_BITS-1:2];
            slot_lq[free_slot]   <= lq_idx;
        end
        // one wakeup per cycle
        if (|rel_vec) begin
            lq_data  <= line_data[slot_miss[rel_slot]][slot_sel[rel_slot]*32 +: 32];
            lq_idx_o <= slot_lq[rel_slot];
        end
    end

endmodule

`default_nettype wire

// File: src/miss_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module miss_alloc (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   ren,
    input  wire miss_pkg::paddr_t                 raddr,
    input  wire                                   slot_free,
    input  wire                                   fetch_issued,
    input  wire miss_pkg::miss_idx_t              fetch_issued_idx,
    input  wire                                   miss_end,
    input  wire miss_pkg::miss_idx_t              miss_end_idx,
    output logic                                  rfull,
    output logic                                  alloc_ok,
    output miss_pkg::miss_idx_t                   alloc_idx,
    output logic [miss_pkg::MISS_ENTRIES-1:0]     entry_valid,
    output miss_pkg::line_addr_t                  entry_line [miss_pkg::MISS_ENTRIES],
    output logic [miss_pkg::MISS_ENTRIES-1:0]     fetch_pending,
    output logic [miss_pkg::MISS_ENTRIES-1:0]     rhit_vec
);

    miss_pkg::line_addr_t                  line;
    logic [miss_pkg::MISS_ENTRIES-1:0]     hit_vec;
    logic                                  hit;
    logic                                  any_free;
    miss_pkg::miss_idx_t                   hit_idx;
    miss_pkg::miss_idx_t                   free_idx;

    assign line = raddr[$bits(miss_pkg::paddr_t)-1:miss_pkg::LINE_OFFSET_BITS];

    // match against live entries, lowest free entry for a new line
    always_comb begin
        hit_idx  = '0;
        free_idx = '0;
        for (int i = miss_pkg::MISS_ENTRIES - 1; i >= 0; i--) begin
            hit_vec[i] = entry_valid[i] && (entry_line[i] == line);
            if (hit_vec[i])
                hit_idx = miss_pkg::miss_idx_t'(i);
            if (!entry_valid[i])
                free_idx = miss_pkg::miss_idx_t'(i);
        end
    end

    assign hit       = |hit_vec;
    assign any_free  = ~&entry_valid;
    assign alloc_ok  = ren && slot_free && (hit || any_free);
    assign alloc_idx = hit ? hit_idx : free_idx;
    // keeps a hit entry alive for this cycle
    assign rhit_vec  = ren ? hit_vec : '0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rfull         <= 1'b0;
            entry_valid   <= '0;
            fetch_pending <= '0;
        end else begin
            rfull <= ren && !alloc_ok;
            if (alloc_ok && !hit) begin
                entry_valid[alloc_idx]   <= 1'b1;
                fetch_pending[alloc_idx] <= 1'b1;
            end
            if (fetch_issued)
                fetch_pending[fetch_issued_idx] <= 1'b0;
            if (miss_end)
                entry_valid[miss_end_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_ok && !hit)
            entry_line[alloc_idx] <= line;
    end

endmodule

`default_nettype wire

// File: src/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // two reads may be in flight
    localparam int MEM_IDS        = 2;
    localparam int BEATS_PER_LINE = 4;

    typedef logic [0:0] mem_id_t;
    typedef logic [1:0] beat_idx_t;

    typedef enum logic {
        IDLE,
        REQ
    } fetch_state_t;

endpackage

`default_nettype wire

// File: src/miss_pkg.sv
`default_nettype none

package miss_pkg;

    localparam int MISS_ENTRIES     = 4;
    localparam int WAIT_SLOTS       = 4;
    localparam int LINE_OFFSET_BITS = 4;

    typedef logic [31:0] paddr_t;
    // address with the byte offset stripped
    typedef logic [27:0] line_addr_t;
    typedef logic [1:0] miss_idx_t;
    typedef logic [4:0] lq_idx_t;
    typedef logic [31:0] word_t;
    typedef logic [1:0] word_sel_t;
    typedef logic [127:0] line_t;

endpackage

`default_nettype wire
